/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_y_filter
FLIST     = flist.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* beat_packer.sv */
`timescale 1ns/1ps

module beat_packer
	import pix_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  out_ready,
	input  logic  lane_valid,
	input  beat_t lane_pixels,
	output logic  advance,
	output logic  out_valid,
	output beat_t out_data
);

	// Output register is free when empty or being drained
	assign advance = !out_valid || out_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (advance) begin
			out_valid <= lane_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			out_data <= lane_pixels;                    // Held while stalled
		end
	end

endmodule

/* filt_pkg.sv */
package filt_pkg;

	// Names the line memory holding the oldest line
	typedef logic [1:0] rot_t;

	// Symmetric 5-tap kernel, sums to 256
	typedef logic [7:0] coeff_t;

	localparam coeff_t H_EDGE   = 8'd6;
	localparam coeff_t H_NEAR   = 8'd58;
	localparam coeff_t H_CENTER = 8'd128;

	// Datapath widths
	typedef logic [15:0] prod_t;                    // Pixel times coefficient
	typedef logic [17:0] sum_t;                     // Weighted sum of five taps

	// Round to nearest, then divide by the kernel sum
	localparam sum_t ROUND_BIAS  = 18'd128;
	localparam int   ROUND_SHIFT = 8;

endpackage

/* flist.f */
pix_pkg.sv
filt_pkg.sv
line_store.sv
y_window.sv
beat_packer.sv
y_filter_top.sv
tb_y_filter.sv

/* line_store.sv */
`timescale 1ns/1ps

module line_store
	import pix_pkg::*, filt_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  advance,
	input  logic  in_valid,
	input  logic  in_first,
	input  beat_t in_data,
	output logic  win_valid,
	output rot_t  win_rot,
	output beat_t win_line0,
	output beat_t win_line1,
	output beat_t win_line2,
	output beat_t win_line3,
	output beat_t win_cur
);

	beat_t    line_mem [STORED_LINES][LINE_BEATS];

	logic     accept;
	logic     line_end;
	logic     lines_full;
	col_t     col;
	col_t     eff_col;
	row_cnt_t row_cnt;
	row_cnt_t eff_row;
	rot_t     rot;
	rot_t     eff_rot;

	assign accept = advance && in_valid;

	// Start of frame restarts position before the beat is handled
	assign eff_col = in_first ? col_t'(0) : col;
	assign eff_row = in_first ? row_cnt_t'(0) : row_cnt;
	assign eff_rot = in_first ? rot_t'(0) : rot;

	assign line_end   = (eff_col == col_t'(LINE_BEATS - 1));
	assign lines_full = (eff_row == row_cnt_t'(STORED_LINES));

	always_ff @(posedge clock) begin
		if (reset) begin
			col       <= '0;
			row_cnt   <= '0;
			rot       <= '0;
			win_valid <= 1'b0;
		end else if (advance) begin
			win_valid <= accept && lines_full;          // Four full lines behind this beat
			if (accept) begin
				if (line_end) begin
					col <= '0;
					rot <= eff_rot + rot_t'(1);         // Next memory now holds the oldest line
					if (lines_full) begin
						row_cnt <= eff_row;
					end else begin
						row_cnt <= eff_row + row_cnt_t'(1);
					end
				end else begin
					col     <= eff_col + col_t'(1);
					rot     <= eff_rot;
					row_cnt <= eff_row;
				end
			end
		end
	end

	// Oldest memory is read before it is overwritten by the current line
	always_ff @(posedge clock) begin
		if (accept) begin
			line_mem[eff_rot][eff_col] <= in_data;
		end
		if (advance) begin
			win_line0 <= line_mem[0][eff_col];
			win_line1 <= line_mem[1][eff_col];
			win_line2 <= line_mem[2][eff_col];
			win_line3 <= line_mem[3][eff_col];
			win_cur   <= in_data;
			win_rot   <= eff_rot;
		end
	end

endmodule

/* pix_pkg.sv */
package pix_pkg;

	// Pixel and beat format
	localparam int PIXEL_BITS = 8;
	localparam int LANES      = 4;                  // Pixels per beat

	typedef logic [PIXEL_BITS-1:0]       pixel_t;
	typedef logic [LANES*PIXEL_BITS-1:0] beat_t;   // Lane 0 in the low byte

	// Line geometry
	localparam int LINE_BEATS   = 4;                // 16 pixels per line
	localparam int STORED_LINES = 4;                // Line memories in the store

	typedef logic [1:0] col_t;                      // Beat index within a line
	typedef logic [2:0] row_cnt_t;                  // Saturates at STORED_LINES

endpackage

/* tb_y_filter.sv */
`timescale 1ns/1ps

module tb_y_filter
	import pix_pkg::*;
();

	localparam int          CLOCK_PERIOD = 100;
	localparam int          RESET_CYCLES = 10;
	localparam logic [31:0] SEED         = 32'd63;
	localparam int          FRAME_LINES  = 12;
	localparam int          LATENCY      = 5;
	localparam int          DRAIN_CYCLES = 64;         // Enough to empty the pipeline under stalls
	localparam int          WATCHDOG_NS  = 5 * FRAME_LINES * LINE_BEATS * 4 * CLOCK_PERIOD;

	// Vertical kernel weights from the oldest line to the current one
	localparam int W_EDGE   = 6;
	localparam int W_NEAR   = 58;
	localparam int W_CENTER = 128;

	logic  clock;
	logic  reset;
	logic  in_valid;
	logic  in_ready;
	beat_t in_data;
	logic  in_first;
	logic  out_valid;
	logic  out_ready;
	beat_t out_data;

	logic [31:0] pix_state   = SEED;
	logic [31:0] ready_state = SEED ^ 32'ha5a5_a5a5;   // Separate stream for back-pressure
	logic        random_mode = 1'b0;

	beat_t hist [STORED_LINES][LINE_BEATS];           // Oldest line in entry 0
	beat_t cur_line [LINE_BEATS];
	int    model_row;
	col_t  model_col;
	beat_t exp_q [$];
	int    exp_index = 0;
	beat_t exp_beat;
	beat_t held_data;
	logic  stalled = 1'b0;
	int    out_count = 0;
	int    seg_start = 0;
	int    cycle_count = 0;
	int    accept_cycle;
	int    latency;
	logic  check_latency = 1'b0;
	logic  latency_armed = 1'b0;
	logic  latency_checked = 1'b0;

	y_filter_top UUT (
		.clock     (clock),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.in_first  (in_first),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	always @(posedge clock) cycle_count <= cycle_count + 1;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic stop_with_failure();
		$display("TEST FAIL");
		$fatal(1, "Simulation stopped on the first failure");
	endtask

	function automatic beat_t expected_beat(input col_t col, input beat_t cur);
		beat_t result;
		int    acc;
		for (int l = 0; l < LANES; l++) begin
			acc = W_EDGE * int'(hist[0][col][l*PIXEL_BITS +: PIXEL_BITS])
				+ W_NEAR * int'(hist[1][col][l*PIXEL_BITS +: PIXEL_BITS])
				+ W_CENTER * int'(hist[2][col][l*PIXEL_BITS +: PIXEL_BITS])
				+ W_NEAR * int'(hist[3][col][l*PIXEL_BITS +: PIXEL_BITS])
				+ W_EDGE * int'(cur[l*PIXEL_BITS +: PIXEL_BITS]);
			result[l*PIXEL_BITS +: PIXEL_BITS] = pixel_t'((acc + 128) >> 8);
		end
		return result;
	endfunction

	task automatic model_accept(input beat_t beat, input logic first);
		if (first) begin
			model_row = 0;
			model_col = col_t'(0);
		end
		if (check_latency && model_row == STORED_LINES && model_col == col_t'(0)) begin
			check_latency = 1'b0;
			latency_armed = 1'b1;                   // First beat of line five
			accept_cycle  = cycle_count;
		end
		if (model_row == STORED_LINES) begin
			exp_q.push_back(expected_beat(model_col, beat));
		end
		cur_line[model_col] = beat;
		if (model_col == col_t'(LINE_BEATS - 1)) begin
			for (int i = 0; i < STORED_LINES - 1; i++) begin
				for (int c = 0; c < LINE_BEATS; c++) begin
					hist[i][c] = hist[i + 1][c];
				end
			end
			for (int c = 0; c < LINE_BEATS; c++) begin
				hist[STORED_LINES - 1][c] = cur_line[c];
			end
			model_col = col_t'(0);
			if (model_row < STORED_LINES) begin
				model_row++;
			end
		end else begin
			model_col = model_col + col_t'(1);
		end
	endtask

	task automatic send_beat(input beat_t beat, input logic first);
		logic idle;
		@(negedge clock);
		idle = 1'b1;
		while (random_mode && idle) begin
			pix_state = xorshift32(pix_state);
			idle      = (pix_state[2:0] == 3'd0);       // Occasional input bubble
			if (idle) begin
				in_valid = 1'b0;
				in_first = 1'b0;
				@(negedge clock);
			end
		end
		in_valid = 1'b1;
		in_data  = beat;
		in_first = first;
		@(posedge clock);
		while (!in_ready) @(posedge clock);
		model_accept(beat, first);
	endtask

	task automatic send_frame(input int num_lines);
		beat_t beat;
		for (int r = 0; r < num_lines; r++) begin
			for (int c = 0; c < LINE_BEATS; c++) begin
				pix_state = xorshift32(pix_state);
				beat      = pix_state;
				send_beat(beat, (r == 0 && c == 0));
			end
		end
	endtask

	task automatic finish_stream(input int out_lines);
		int waited;
		@(negedge clock);
		in_valid = 1'b0;
		in_first = 1'b0;
		waited   = 0;
		while (exp_index != exp_q.size() && waited < DRAIN_CYCLES) begin
			@(negedge clock);
			waited++;
		end
		repeat (8) @(negedge clock);                   // Room for a stray beat to show up
		assert (out_count - seg_start == out_lines * LINE_BEATS) else begin
			$display("MISMATCH output beat count: expected %h, got %h",
				out_lines * LINE_BEATS, out_count - seg_start);
			stop_with_failure();
		end
		seg_start = out_count;
	endtask

	// Random back-pressure
	initial begin
		out_ready = 1'b1;
		forever begin
			@(negedge clock);
			if (random_mode) begin
				ready_state = xorshift32(ready_state);
				out_ready   = (ready_state[1:0] != 2'b00);
			end else begin
				out_ready = 1'b1;
			end
		end
	end

	a_valid_held: assert property (@(posedge clock) disable iff (reset)
		$past(out_valid && !out_ready) |-> out_valid)
		else begin
			$display("MISMATCH out_valid: expected 1, got 0 while stalled");
			stop_with_failure();
		end

	always @(posedge clock) begin
		if (reset) begin
			stalled = 1'b0;
		end else begin
			if (stalled) begin
				assert (out_data == held_data) else begin
					$display("MISMATCH out_data: held %h, now %h", held_data, out_data);
					stop_with_failure();
				end
			end
			if (out_valid && out_ready) begin
				assert (exp_index < exp_q.size()) else begin
					$display("Output beat %h arrived with no expected beat pending", out_data);
					stop_with_failure();
				end
				exp_beat = exp_q[exp_index];
				exp_index++;
				out_count++;
				assert (out_data == exp_beat) else begin
					$display("MISMATCH out_data: expected %h, got %h", exp_beat, out_data);
					stop_with_failure();
				end
			end
			if (latency_armed && !latency_checked && out_valid) begin
				latency_checked = 1'b1;
				latency = cycle_count - 1 - accept_cycle;    // out_valid rose one edge earlier
				assert (latency == LATENCY) else begin
					$display("MISMATCH first output latency: expected %h, got %h",
						LATENCY, latency);
					stop_with_failure();
				end
			end
			stalled   = out_valid && !out_ready;
			held_data = out_data;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all frames were checked");
		stop_with_failure();
	end

	initial begin
		reset     = 1'b1;
		in_valid  = 1'b0;
		in_data   = '0;
		in_first  = 1'b0;
		model_row = 0;
		model_col = col_t'(0);
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		@(posedge clock);
		assert (out_valid == 1'b0) else begin
			$display("MISMATCH out_valid after reset: expected 0, got %h", out_valid);
			stop_with_failure();
		end
		assert (in_ready == 1'b1) else begin
			$display("MISMATCH in_ready after reset: expected 1, got %h", in_ready);
			stop_with_failure();
		end

		check_latency = 1'b1;                          // Output always ready in this frame
		send_frame(FRAME_LINES);
		finish_stream(FRAME_LINES - STORED_LINES);
		assert (latency_checked) else begin
			$display("First output beat of the frame was never seen");
			stop_with_failure();
		end

		@(posedge clock);
		random_mode = 1'b1;
		send_frame(FRAME_LINES);
		finish_stream(FRAME_LINES - STORED_LINES);

		// Frame cut short by in_first halfway through
		send_frame(FRAME_LINES / 2);
		send_frame(FRAME_LINES);
		finish_stream(FRAME_LINES / 2 - STORED_LINES + FRAME_LINES - STORED_LINES);

		$display("TEST PASS");
		$finish;
	end

endmodule

/* y_filter_top.sv */
`timescale 1ns/1ps

module y_filter_top
	import pix_pkg::*, filt_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  in_valid,
	output logic  in_ready,
	input  beat_t in_data,
	input  logic  in_first,
	output logic  out_valid,
	input  logic  out_ready,
	output beat_t out_data
);

	logic             advance;
	logic             win_valid;
	rot_t             win_rot;
	beat_t            win_line0, win_line1, win_line2, win_line3, win_cur;
	logic [LANES-1:0] lane_valid;
	beat_t            lane_pixels;

	assign in_ready = advance;

	line_store u_line_store (
		.clock     (clock),
		.reset     (reset),
		.advance   (advance),
		.in_valid  (in_valid),
		.in_first  (in_first),
		.in_data   (in_data),
		.win_valid (win_valid),
		.win_rot   (win_rot),
		.win_line0 (win_line0),
		.win_line1 (win_line1),
		.win_line2 (win_line2),
		.win_line3 (win_line3),
		.win_cur   (win_cur)
	);

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		y_window u_y_window (
			.clock      (clock),
			.reset      (reset),
			.advance    (advance),
			.win_valid  (win_valid),
			.win_rot    (win_rot),
			.din0       (win_line0[i*PIXEL_BITS +: PIXEL_BITS]),
			.din1       (win_line1[i*PIXEL_BITS +: PIXEL_BITS]),
			.din2       (win_line2[i*PIXEL_BITS +: PIXEL_BITS]),
			.din3       (win_line3[i*PIXEL_BITS +: PIXEL_BITS]),
			.din4       (win_cur[i*PIXEL_BITS +: PIXEL_BITS]),
			.lane_valid (lane_valid[i]),
			.lane_pixel (lane_pixels[i*PIXEL_BITS +: PIXEL_BITS])
		);
	end

	// All lanes run in lockstep, lane 0 speaks for the beat
	beat_packer u_beat_packer (
		.clock       (clock),
		.reset       (reset),
		.out_ready   (out_ready),
		.lane_valid  (lane_valid[0]),
		.lane_pixels (lane_pixels),
		.advance     (advance),
		.out_valid   (out_valid),
		.out_data    (out_data)
	);

endmodule

/* y_window.sv */
`timescale 1ns/1ps

module y_window
	import pix_pkg::*, filt_pkg::*;
(
	input  logic   clock,
	input  logic   reset,
	input  logic   advance,
	input  logic   win_valid,
	input  rot_t   win_rot,
	input  pixel_t din0,
	input  pixel_t din1,
	input  pixel_t din2,
	input  pixel_t din3,
	input  pixel_t din4,
	output logic   lane_valid,
	output pixel_t lane_pixel
);

	coeff_t coeff0, coeff1, coeff2, coeff3;

	prod_t  prod0, prod1, prod2, prod3, prod4;
	sum_t   pair01, pair23, edge_d;
	sum_t   total;
	sum_t   rounded;

	logic   valid_prod, valid_pair, valid_total;

	// Oldest memory gets the edge tap, the others follow in age order
	always_comb begin
		case (win_rot)
			2'd0: begin
				coeff0 = H_EDGE;
				coeff1 = H_NEAR;
				coeff2 = H_CENTER;
				coeff3 = H_NEAR;
			end
			2'd1: begin
				coeff0 = H_NEAR;
				coeff1 = H_EDGE;
				coeff2 = H_NEAR;
				coeff3 = H_CENTER;
			end
			2'd2: begin
				coeff0 = H_CENTER;
				coeff1 = H_NEAR;
				coeff2 = H_EDGE;
				coeff3 = H_NEAR;
			end
			default: begin
				coeff0 = H_NEAR;
				coeff1 = H_CENTER;
				coeff2 = H_NEAR;
				coeff3 = H_EDGE;
			end
		endcase
	end

	assign rounded = total + ROUND_BIAS;

	always_ff @(posedge clock) begin
		if (advance) begin
			prod0 <= din0 * coeff0;
			prod1 <= din1 * coeff1;
			prod2 <= din2 * coeff2;
			prod3 <= din3 * coeff3;
			prod4 <= din4 * H_EDGE;                     // Current line is always an edge tap

			pair01 <= sum_t'(prod0) + sum_t'(prod1);
			pair23 <= sum_t'(prod2) + sum_t'(prod3);
			edge_d <= sum_t'(prod4);

			total <= pair01 + pair23 + edge_d;

			lane_pixel <= rounded[ROUND_SHIFT +: PIXEL_BITS];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_prod  <= 1'b0;
			valid_pair  <= 1'b0;
			valid_total <= 1'b0;
			lane_valid  <= 1'b0;
		end else if (advance) begin
			valid_prod  <= win_valid;
			valid_pair  <= valid_prod;
			valid_total <= valid_pair;
			lane_valid  <= valid_total;
		end
	end

endmodule
